// File: design/md5_fmt_pkg.sv
`default_nettype none

package md5_fmt_pkg;

	// running byte total is 16 bits, up to 64 KiB per message
	localparam int TOTAL_MSB = 15;

	// message memory, 256 words of 32 bits
	localparam int MEM_AW = 8;
	localparam int BYTE_AW = MEM_AW + 2;

	// md5 block is 16 words
	localparam int BLK_WORDS = 16;

	// host command opcode
	typedef enum logic {
		CMD_BYTES  = 1'b0,
		CMD_FINISH = 1'b1
	} cmd_op_e;

	// fetch engine: first word may be unaligned, the rest are not
	typedef enum logic [1:0] {
		F_IDLE,
		F_FIRST,
		F_REST
	} fetch_state_e;

	// command dispatcher and padding sequence
	typedef enum logic [2:0] {
		P_IDLE,
		P_FETCH,
		P_0X80,
		P_ALIGN0,
		P_ZERO,
		P_TOTAL_LO,
		P_TOTAL_HI
	} pad_state_e;

endpackage

`default_nettype wire

// File: design/realign_in_if.sv
`timescale 1ns/10ps
`default_nettype none

interface realign_in_if (
	input wire CLK
);
	import md5_fmt_pkg::*;

	// message words from the fetch engine
	logic wr_en;
	logic [2:0] len;
	logic [1:0] off;
	logic [31:0] din;

	// padding controls from the dispatcher, pad_len is their byte count
	logic add0x80pad;
	logic add0pad;
	logic add_total;
	logic [2:0] pad_len;
	logic [TOTAL_MSB:0] in_total;

	modport fetch (output wr_en, len, off, din);
	modport pad (output add0x80pad, add0pad, add_total, pad_len, in_total);
	modport sink (input wr_en, len, off, din, add0x80pad, add0pad, add_total, pad_len, in_total);

	// data words and padding come from two blocks, never on the same cycle
	a_no_overlap: assert property (@(posedge CLK)
		disable iff ($isunknown({wr_en, add0x80pad, add0pad, add_total}))
		!(wr_en && (add0x80pad || add0pad || add_total)));

endinterface

`default_nettype wire

// File: design/realign4_pad.sv
`timescale 1ns/10ps
`default_nettype none

module realign4_pad (
	input wire CLK,
	input wire rst,
	realign_in_if.sink src,
	output logic valid,
	output logic [31:0] out,
	output logic err
);
	import md5_fmt_pkg::*;

	logic strobe;
	logic [31:0] bit_total;
	logic [31:0] in_sel;

	// input stage
	logic in_wr;
	logic [2:0] in_len;
	logic [1:0] in_off;
	logic [31:0] in_word;

	// output word and carry-over bytes
	logic [31:0] acc;
	logic [2:0] acc_cnt;
	logic [23:0] ovf;
	logic [2:0] ovf_cnt;

	// merge window
	logic [2:0] base;
	logic [2:0] eff_len;
	logic [2:0] sum;
	logic [23:0] old_vec;
	logic [23:0] old_mask;
	logic [55:0] win;

	assign strobe = src.wr_en | src.add0x80pad | src.add0pad | src.add_total;

	// bit length, low word, little-endian bytes
	assign bit_total = {{(28 - TOTAL_MSB){1'b0}}, src.in_total, 3'b000};

	// pick payload, unaligned data shifted down to byte 0
	always_comb begin
		if (src.add0x80pad)
			in_sel = 32'h0000_0080;
		else if (src.add_total)
			in_sel = bit_total;
		else if (src.add0pad)
			in_sel = '0;
		else
			in_sel = src.din >> {src.off, 3'b000};
	end

	always_ff @(posedge CLK) begin
		if (rst)
			in_wr <= 1'b0;
		else
			in_wr <= strobe;
	end

	// byte count from whichever side strobed
	always_ff @(posedge CLK) begin
		in_word <= in_sel;
		in_len <= src.wr_en ? src.len : src.pad_len;
		in_off <= src.wr_en ? src.off : 2'd0;
	end

	// fill position for the new bytes
	// carry bytes go first, a full output word counts as empty
	always_comb begin
		if (ovf_cnt != 3'd0)
			base = ovf_cnt;
		else if (acc_cnt[2])
			base = 3'd0;
		else
			base = acc_cnt;
		old_vec = (ovf_cnt != 3'd0) ? ovf : acc[23:0];
		old_mask = ~(24'hFF_FFFF << {base, 3'b000});
		eff_len = in_wr ? in_len : 3'd0;
		sum = base + eff_len;
		win = ({24'h0, in_word} << {base, 3'b000}) | {32'h0, old_vec & old_mask};
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			acc_cnt <= 3'd0;
			ovf_cnt <= 3'd0;
			valid <= 1'b0;
			err <= 1'b0;
		end else begin
			// whole word leaves, remainder waits in the carry register
			valid <= sum[2];
			if (sum[2]) begin
				acc_cnt <= 3'd4;
				ovf_cnt <= {1'b0, sum[1:0]};
			end else begin
				acc_cnt <= sum;
				ovf_cnt <= 3'd0;
			end

			// zero-length strobe
			if (in_wr && in_len == 3'd0)
				err <= 1'b1;
			// unaligned start only on an empty word, and it can not fill it
			if (in_wr && in_off != 2'd0 && (base != 3'd0 || in_len[2]))
				err <= 1'b1;
		end
	end

	// low bytes of the window always hold the live data
	always_ff @(posedge CLK) begin
		acc <= win[31:0];
		ovf <= win[55:32];
	end

	assign out = acc;

	// a strobe brings at most 4 bytes, so no more than 3 carry over
	a_ovf_max: assert property (@(posedge CLK) disable iff (rst)
		in_wr |-> in_len <= 3'd4);

endmodule

`default_nettype wire

// File: design/word_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module word_fetch (
	input wire CLK,
	input wire rst,
	input wire mem_we,
	input wire [md5_fmt_pkg::MEM_AW-1:0] mem_addr,
	input wire [31:0] mem_wdata,
	input wire fetch_start,
	input wire [md5_fmt_pkg::BYTE_AW-1:0] fetch_addr,
	input wire [md5_fmt_pkg::BYTE_AW-1:0] fetch_len,
	output logic fetch_done,
	realign_in_if.fetch src
);
	import md5_fmt_pkg::*;

	logic [31:0] mem [0:(1 << MEM_AW) - 1];

	fetch_state_e state;
	logic [MEM_AW-1:0] waddr;
	logic [BYTE_AW-1:0] remain;
	logic [1:0] first_off;
	logic [2:0] cap;
	logic [2:0] step;
	logic last_word;

	// read stage
	logic [31:0] rd_data;
	logic s_wr;
	logic s_last;
	logic [2:0] s_len;
	logic [1:0] s_off;

	// host write port
	always_ff @(posedge CLK) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
	end

	// bytes available in the current word
	assign cap = (state == F_FIRST) ? 3'd4 - {1'b0, first_off} : 3'd4;
	assign step = (remain < BYTE_AW'(cap)) ? remain[2:0] : cap;
	assign last_word = remain == BYTE_AW'(step);

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= F_IDLE;
			s_wr <= 1'b0;
		end else begin
			s_wr <= state != F_IDLE;
			case (state)
				F_IDLE:
					if (fetch_start)
						state <= F_FIRST;
				F_FIRST, F_REST:
					state <= last_word ? F_IDLE : F_REST;
				default:
					state <= F_IDLE;
			endcase
		end
	end

	// address walk, loaded on start
	always_ff @(posedge CLK) begin
		if (state == F_IDLE) begin
			if (fetch_start) begin
				waddr <= fetch_addr[BYTE_AW-1:2];
				remain <= fetch_len;
				first_off <= fetch_addr[1:0];
			end
		end else begin
			waddr <= waddr + MEM_AW'(1);
			remain <= remain - BYTE_AW'(step);
		end
	end

	// registered read, length and offset follow the data
	always_ff @(posedge CLK) begin
		rd_data <= mem[waddr];
		s_len <= step;
		s_off <= (state == F_FIRST) ? first_off : 2'd0;
		s_last <= last_word;
	end

	assign src.wr_en = s_wr;
	assign src.len = s_len;
	assign src.off = s_off;
	assign src.din = rd_data;
	assign fetch_done = s_wr & s_last;

	a_len_range: assert property (@(posedge CLK) disable iff (rst)
		src.wr_en |-> src.len inside {[3'd1:3'd4]});

endmodule

`default_nettype wire

// File: design/fmt_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fmt_ctrl (
	input wire CLK,
	input wire rst,
	input wire cmd_start,
	input wire md5_fmt_pkg::cmd_op_e cmd_op,
	input wire [md5_fmt_pkg::BYTE_AW-1:0] cmd_addr,
	input wire [md5_fmt_pkg::BYTE_AW-1:0] cmd_len,
	input wire fetch_done,
	output logic busy,
	output logic fetch_start,
	output logic [md5_fmt_pkg::BYTE_AW-1:0] fetch_addr,
	output logic [md5_fmt_pkg::BYTE_AW-1:0] fetch_len,
	realign_in_if.pad ctl
);
	import md5_fmt_pkg::*;

	pad_state_e state;
	pad_state_e state_nx;
	logic [TOTAL_MSB:0] total;
	// byte position within the 64-byte block
	logic [5:0] pos;
	logic [5:0] pos_nx;
	logic [2:0] step;
	logic accept;
	logic bytes_go;

	assign busy = state != P_IDLE;
	assign accept = cmd_start && !busy;
	// zero-length byte commands are dropped
	assign bytes_go = accept && cmd_op == CMD_BYTES && cmd_len != '0;

	// one pad strobe per state
	assign ctl.add0x80pad = state == P_0X80;
	assign ctl.add0pad = state == P_ALIGN0 || state == P_ZERO || state == P_TOTAL_HI;
	assign ctl.add_total = state == P_TOTAL_LO;
	assign ctl.pad_len = step;
	assign ctl.in_total = total;

	always_comb begin
		case (state)
			P_0X80:
				step = 3'd1;
			P_ALIGN0:
				step = 3'd4 - {1'b0, pos[1:0]};
			P_ZERO, P_TOTAL_LO, P_TOTAL_HI:
				step = 3'd4;
			default:
				step = 3'd0;
		endcase
	end

	assign pos_nx = pos + {3'b000, step};

	always_comb begin
		state_nx = state;
		case (state)
			P_IDLE:
				if (bytes_go)
					state_nx = P_FETCH;
				else if (accept && cmd_op == CMD_FINISH)
					state_nx = P_0X80;
			P_FETCH:
				if (fetch_done)
					state_nx = P_IDLE;
			// word alignment first, then zeros up to byte 56
			P_0X80:
				if (pos_nx[1:0] != 2'd0)
					state_nx = P_ALIGN0;
				else
					state_nx = (pos_nx == 6'd56) ? P_TOTAL_LO : P_ZERO;
			P_ALIGN0, P_ZERO:
				state_nx = (pos_nx == 6'd56) ? P_TOTAL_LO : P_ZERO;
			P_TOTAL_LO:
				state_nx = P_TOTAL_HI;
			default:
				state_nx = P_IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= P_IDLE;
			total <= '0;
			pos <= '0;
			fetch_start <= 1'b0;
		end else begin
			state <= state_nx;
			fetch_start <= bytes_go;
			if (bytes_go)
				total <= total + {{(TOTAL_MSB + 1 - BYTE_AW){1'b0}}, cmd_len};
			// padding starts where the message ends
			if (accept && cmd_op == CMD_FINISH)
				pos <= total[5:0];
			else if (state != P_IDLE && state != P_FETCH)
				pos <= pos_nx;
			// message closed
			if (state == P_TOTAL_HI)
				total <= '0;
		end
	end

	// range latched with the start pulse
	always_ff @(posedge CLK) begin
		if (bytes_go) begin
			fetch_addr <= cmd_addr;
			fetch_len <= cmd_len;
		end
	end

	// fetch engine finishes only the range this block launched
	a_done_in_fetch: assert property (@(posedge CLK) disable iff (rst)
		fetch_done |-> state == P_FETCH);

endmodule

`default_nettype wire

// File: design/block_collect.sv
`timescale 1ns/10ps
`default_nettype none

module block_collect (
	input wire CLK,
	input wire rst,
	input wire valid,
	input wire [31:0] word,
	output logic blk_word_valid,
	output logic [31:0] blk_word,
	output logic [3:0] blk_word_idx,
	output logic blk_last
);
	import md5_fmt_pkg::*;

	// word position inside the current block
	logic [3:0] idx;

	always_ff @(posedge CLK) begin
		if (rst) begin
			idx <= 4'd0;
			blk_word_valid <= 1'b0;
			blk_word_idx <= 4'd0;
			blk_last <= 1'b0;
		end else begin
			blk_word_valid <= valid;
			blk_last <= valid && idx == 4'(BLK_WORDS - 1);
			if (valid) begin
				blk_word_idx <= idx;
				// wraps after word 15
				idx <= idx + 4'd1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (valid)
			blk_word <= word;
	end

endmodule

`default_nettype wire

// File: design/md5_block_fmt.sv
`timescale 1ns/10ps
`default_nettype none

module md5_block_fmt (
	input wire CLK,
	input wire rst,
	input wire mem_we,
	input wire [md5_fmt_pkg::MEM_AW-1:0] mem_addr,
	input wire [31:0] mem_wdata,
	input wire cmd_start,
	input wire md5_fmt_pkg::cmd_op_e cmd_op,
	input wire [md5_fmt_pkg::BYTE_AW-1:0] cmd_addr,
	input wire [md5_fmt_pkg::BYTE_AW-1:0] cmd_len,
	output logic busy,
	output logic blk_word_valid,
	output logic [31:0] blk_word,
	output logic [3:0] blk_word_idx,
	output logic blk_last,
	output logic err
);
	import md5_fmt_pkg::*;

	logic fetch_start;
	logic fetch_done;
	logic [BYTE_AW-1:0] fetch_addr;
	logic [BYTE_AW-1:0] fetch_len;
	logic word_valid;
	logic [31:0] word_out;

	// realigner input bus
	realign_in_if rin (.CLK(CLK));

	word_fetch u_fetch (
		.CLK(CLK),
		.rst(rst),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.fetch_start(fetch_start),
		.fetch_addr(fetch_addr),
		.fetch_len(fetch_len),
		.fetch_done(fetch_done),
		.src(rin.fetch)
	);

	fmt_ctrl u_ctrl (
		.CLK(CLK),
		.rst(rst),
		.cmd_start(cmd_start),
		.cmd_op(cmd_op),
		.cmd_addr(cmd_addr),
		.cmd_len(cmd_len),
		.fetch_done(fetch_done),
		.busy(busy),
		.fetch_start(fetch_start),
		.fetch_addr(fetch_addr),
		.fetch_len(fetch_len),
		.ctl(rin.pad)
	);

	realign4_pad u_realign (
		.CLK(CLK),
		.rst(rst),
		.src(rin.sink),
		.valid(word_valid),
		.out(word_out),
		.err(err)
	);

	block_collect u_collect (
		.CLK(CLK),
		.rst(rst),
		.valid(word_valid),
		.word(word_out),
		.blk_word_valid(blk_word_valid),
		.blk_word(blk_word),
		.blk_word_idx(blk_word_idx),
		.blk_last(blk_last)
	);

endmodule

`default_nettype wire

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected output bytes, oldest first
logic [7:0] exp_bytes [$];
// copy of the message memory as the host wrote it
logic [31:0] mem_copy [0:(1 << MEM_AW) - 1];
logic [TOTAL_MSB:0] model_total;
logic [3:0] exp_idx;

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		errors++;
		$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

// message bytes in memory order, byte 0 of a word in bits 7..0
function automatic void push_range(input logic [BYTE_AW-1:0] addr,
	input logic [BYTE_AW-1:0] len);
	logic [BYTE_AW-1:0] a;
	logic [31:0] w;
	for (int k = 0; k < int'(len); k++) begin
		a = addr + BYTE_AW'(k);
		w = mem_copy[a[BYTE_AW-1:2]];
		exp_bytes.push_back(w[{a[1:0], 3'b000} +: 8]);
	end
	model_total = model_total + (TOTAL_MSB + 1)'(len);
endfunction

// md5 padding: 0x80, zeros up to byte 56 of a block, bit length low then high word
function automatic void push_padding();
	logic [31:0] bits;
	logic [5:0] pos;
	bits = 32'(model_total) << 3;
	exp_bytes.push_back(8'h80);
	pos = model_total[5:0] + 6'd1;
	while (pos != 6'd56) begin
		exp_bytes.push_back(8'h00);
		pos = pos + 6'd1;
	end
	repeat (4) begin
		exp_bytes.push_back(bits[7:0]);
		bits = bits >> 8;
	end
	// high word, messages stay under 64 KiB
	repeat (4) exp_bytes.push_back(8'h00);
	model_total = '0;
endfunction

// one output word against the next four expected bytes
task automatic compare_word();
	logic [31:0] w;
	if (exp_bytes.size() < 4) begin
		errors++;
		$display("output word %h at %0t arrived with no expected bytes left", blk_word, $time);
	end else begin
		w = '0;
		// first byte ends up in bits 7..0
		repeat (4) w = {exp_bytes.pop_front(), w[31:8]};
		check_value("blk_word", blk_word, w);
		check_value("blk_word_idx", 32'(blk_word_idx), 32'(exp_idx));
		check_value("blk_last", 32'(blk_last), 32'(exp_idx == 4'(BLK_WORDS - 1)));
		exp_idx = exp_idx + 4'd1;
	end
endtask

`endif

// File: testbench/tb_md5_block_fmt.sv
`timescale 1ns/10ps
`default_nettype none

module tb_md5_block_fmt;
	import md5_fmt_pkg::*;

	// cycles allowed for any single wait
	localparam int TIMEOUT = 3000;

	logic CLK;
	logic rst;
	logic mem_we;
	logic [MEM_AW-1:0] mem_addr;
	logic [31:0] mem_wdata;
	logic cmd_start;
	cmd_op_e cmd_op;
	logic [BYTE_AW-1:0] cmd_addr;
	logic [BYTE_AW-1:0] cmd_len;
	logic busy;
	logic blk_word_valid;
	logic [31:0] blk_word;
	logic [3:0] blk_word_idx;
	logic blk_last;
	logic err;

	int errors;
	logic [31:0] rng;
	// output compare off while err is forced
	logic check_en;
	// set once a wait ran out, later waits return at once
	bit stalled;

	`include "tb_model.svh"

	md5_block_fmt DUT (
		.CLK(CLK),
		.rst(rst),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.cmd_start(cmd_start),
		.cmd_op(cmd_op),
		.cmd_addr(cmd_addr),
		.cmd_len(cmd_len),
		.busy(busy),
		.blk_word_valid(blk_word_valid),
		.blk_word(blk_word),
		.blk_word_idx(blk_word_idx),
		.blk_last(blk_last),
		.err(err)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	// outputs settle after the rising edge, sample on the falling one
	always @(negedge CLK) begin
		if (check_en && blk_word_valid)
			compare_word();
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y ^= y << 13;
		y ^= y >> 17;
		y ^= y << 5;
		return y;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		rng = xorshift(rng);
		return rng % n;
	endfunction

	task automatic close_run();
		$display("checks finished with %0d errors", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge CLK);
		while (busy && !stalled) begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT) begin
				errors++;
				stalled = 1'b1;
				$display("timeout at %0t, busy never fell", $time);
			end
		end
	endtask

	// one command, model updated once the DUT took it
	task automatic issue_cmd(input cmd_op_e op, input logic [BYTE_AW-1:0] addr,
		input logic [BYTE_AW-1:0] len);
		wait_idle();
		@(posedge CLK);
		cmd_start <= 1'b1;
		cmd_op <= op;
		cmd_addr <= addr;
		cmd_len <= len;
		@(posedge CLK);
		cmd_start <= 1'b0;
		if (op == CMD_BYTES)
			push_range(addr, len);
		else
			push_padding();
	endtask

	task automatic wait_drained();
		int n;
		wait_idle();
		n = 0;
		while (exp_bytes.size() != 0 && !stalled) begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT) begin
				errors++;
				stalled = 1'b1;
				$display("timeout at %0t, %0d expected bytes never came out", $time,
					exp_bytes.size());
			end
		end
	endtask

	// random byte commands, then finish
	task automatic run_message(input int n_cmds, input bit mult4, input int max_gap);
		logic [BYTE_AW-1:0] addr;
		logic [BYTE_AW-1:0] len;
		for (int c = 0; c < n_cmds; c++) begin
			if (mult4)
				len = BYTE_AW'(4 * rand_below(40));
			else
				len = BYTE_AW'(rand_below(120));
			addr = BYTE_AW'(rand_below((1 << BYTE_AW) - int'(len)));
			// unaligned start only on a whole stream word
			if (model_total[1:0] != 2'b00)
				addr[1:0] = 2'b00;
			issue_cmd(CMD_BYTES, addr, len);
			repeat (rand_below(max_gap + 1)) @(posedge CLK);
		end
		issue_cmd(CMD_FINISH, '0, '0);
		wait_drained();
	endtask

	initial begin : main
		logic [31:0] w;
		logic [BYTE_AW-1:0] len;
		errors = 0;
		stalled = 1'b0;
		rng = 32'd34989;
		check_en = 1'b1;
		model_total = '0;
		exp_idx = '0;
		rst = 1'b1;
		mem_we = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		cmd_start = 1'b0;
		cmd_op = CMD_BYTES;
		cmd_addr = '0;
		cmd_len = '0;
		repeat (3) @(posedge CLK);
		rst <= 1'b0;
		@(negedge CLK);
		check_value("busy", 32'(busy), 32'd0);
		check_value("err", 32'(err), 32'd0);

		// random fill, every word mixed with its address
		for (int i = 0; i < (1 << MEM_AW); i++) begin
			w = rng ^ {4{8'(i)}};
			void'(rand_below(2));
			@(posedge CLK);
			mem_we <= 1'b1;
			mem_addr <= MEM_AW'(i);
			mem_wdata <= w;
			mem_copy[MEM_AW'(i)] = w;
		end
		@(posedge CLK);
		mem_we <= 1'b0;

		// aligned message
		issue_cmd(CMD_BYTES, BYTE_AW'(64), BYTE_AW'(200));
		issue_cmd(CMD_FINISH, '0, '0);
		wait_drained();

		// unaligned starts, stream stays word aligned between commands
		repeat (10) run_message(4, 1'b1, 3);

		// message end at every position in the block
		for (int p = 0; p < 64; p++) begin
			len = BYTE_AW'(p + 64 * int'(rand_below(3)));
			issue_cmd(CMD_BYTES, BYTE_AW'(rand_below((1 << BYTE_AW) - int'(len))), len);
			issue_cmd(CMD_FINISH, '0, '0);
			wait_drained();
		end

		// back to back, mixed lengths and idle gaps
		repeat (20) run_message(1 + int'(rand_below(5)), 1'b0, 6);
		check_value("err", 32'(err), 32'd0);

		// unaligned start after 3 bytes
		check_en = 1'b0;
		issue_cmd(CMD_BYTES, BYTE_AW'(0), BYTE_AW'(3));
		issue_cmd(CMD_BYTES, BYTE_AW'(5), BYTE_AW'(2));
		wait_idle();
		repeat (4) @(negedge CLK);
		check_value("err", 32'(err), 32'd1);
		issue_cmd(CMD_FINISH, '0, '0);
		wait_idle();
		repeat (20) @(negedge CLK);
		// sticky until reset
		check_value("err", 32'(err), 32'd1);
		@(posedge CLK);
		rst <= 1'b1;
		repeat (3) @(posedge CLK);
		rst <= 1'b0;
		exp_bytes.delete();
		exp_idx = '0;
		model_total = '0;
		@(negedge CLK);
		check_value("err", 32'(err), 32'd0);
		check_en = 1'b1;
		issue_cmd(CMD_BYTES, BYTE_AW'(128), BYTE_AW'(96));
		issue_cmd(CMD_FINISH, '0, '0);
		wait_drained();
		check_value("err", 32'(err), 32'd0);

		close_run();
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
design/md5_fmt_pkg.sv
design/realign_in_if.sv
design/realign4_pad.sv
design/word_fetch.sv
design/fmt_ctrl.sv
design/block_collect.sv
design/md5_block_fmt.sv
testbench/tb_md5_block_fmt.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_md5_block_fmt --Mdir obj_dir

./obj_dir/Vtb_md5_block_fmt > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
